/* run.sh */
#!/usr/bin/env bash
# build and run the front end regression with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
   --timescale 1ns/1ps \
   -f src.f \
   --top-module tb_frontend \
   -Mdir obj_dir \
   -o tb_frontend

# a $fatal in the run gives a non-zero exit status
./obj_dir/tb_frontend

/* src.f */
src/adc_pkg.sv
src/adc_channel.sv
src/bridge_control.sv
src/resonant_frontend_top.sv
verification/frontend_chk.sv
verification/tb_frontend.sv

/* src/adc_channel.sv */
// Single ADC channel capture
`timescale 1ns/1ps
`default_nettype none

module adc_channel
   import adc_pkg::*;
(
   input  wire          ADA_DCO,
   input  wire          i_reset,
   // raw pins from the converter
   input  wire t_adc_raw i_data,
   input  wire          i_over_range,
   // 1 selects two's complement
   input  wire          i_format,
   output t_chan_status o_status
);

   // ========================================================================
   // format normalization
   // ========================================================================

   t_sample sample_next;
   logic    positive_next;

   always_comb begin
      if (i_format) begin
         // already two's complement
         sample_next = t_sample'(i_data);
      end else begin
         // offset binary, flip the msb
         sample_next = t_sample'({~i_data[ADC_WIDTH-1], i_data[ADC_WIDTH-2:0]});
      end
      positive_next = ~sample_next[ADC_WIDTH-1];
   end

   // ========================================================================
   // status register
   // ========================================================================

   // the registered positive flag is the previous sign seen by the
   // crossing detector, so the strobe lines up with the new sign
   always_ff @(posedge ADA_DCO) begin
      if (i_reset) begin
         o_status.sample     <= '0;
         o_status.positive   <= 1'b1;
         o_status.crossing   <= 1'b0;
         o_status.over_range <= 1'b0;
      end else begin
         o_status.sample     <= sample_next;
         o_status.positive   <= positive_next;
         // one cycle high when the sign flips
         o_status.crossing   <= positive_next ^ o_status.positive;
         o_status.over_range <= i_over_range;
      end
   end

endmodule

`default_nettype wire

/* src/adc_pkg.sv */
// ADC front end shared types
`default_nettype none

package adc_pkg;

   // ========================================================================
   // converter widths and codes
   // ========================================================================

   // data bits delivered by each ADC channel
   localparam int ADC_WIDTH = 14;

   // offset binary code for a zero input
   localparam logic [ADC_WIDTH-1:0] MID_SCALE = 14'd8192;

   // ========================================================================
   // sample and status types
   // ========================================================================

   // raw word as seen on the ADC pins or sent to the DAC
   typedef logic [ADC_WIDTH-1:0] t_adc_raw;

   // normalized sample, two's complement
   typedef logic signed [ADC_WIDTH-1:0] t_sample;

   // per channel result, 17 bits
   typedef struct packed {
      t_sample sample;
      // zero counts as positive
      logic    positive;
      // one cycle pulse on a sign change
      logic    crossing;
      logic    over_range;
   } t_chan_status;

   // half bridge gate pair
   typedef struct packed {
      logic hi;
      logic lo;
   } t_gate;

   // {positive A, positive B}
   typedef logic [1:0] t_quadrant;

endpackage

`default_nettype wire

/* src/bridge_control.sv */
// Bridge gate drive and DAC copy-out
`timescale 1ns/1ps
`default_nettype none

module bridge_control
   import adc_pkg::*;
#(
   parameter int DEAD_TIME = 4
) (
   input  wire          ADA_DCO,
   input  wire          i_reset,
   input  wire t_chan_status i_chan_a,
   input  wire t_chan_status i_chan_b,
   // converter on switch
   input  wire          i_enable,
   output t_adc_raw     o_da,
   output t_adc_raw     o_db,
   output t_quadrant    o_quadrant,
   output t_gate        o_gate,
   // active low
   output logic [7:0]   o_leds
);

   // counter holds up to DEAD_TIME-1
   localparam int CNT_W = (DEAD_TIME > 1) ? $clog2(DEAD_TIME) : 1;
   localparam logic [CNT_W-1:0] DEAD_LOAD = CNT_W'(DEAD_TIME - 1);

   // back to offset binary for the DAC
   function automatic t_adc_raw to_offset(input t_sample s);
      return {~s[ADC_WIDTH-1], s[ADC_WIDTH-2:0]};
   endfunction

   // ========================================================================
   // DAC words, quadrant and status LEDs
   // ========================================================================

   logic [7:0] leds_next;

   always_comb begin
      // unused LEDs stay dark
      leds_next    = 8'hFF;
      leds_next[0] = ~i_enable;
      leds_next[3] = ~(i_enable & i_chan_a.over_range);
      leds_next[4] = ~(i_enable & i_chan_b.over_range);
   end

   always_ff @(posedge ADA_DCO) begin
      if (i_reset) begin
         o_da       <= MID_SCALE;
         o_db       <= MID_SCALE;
         o_quadrant <= '0;
         o_leds     <= 8'hFF;
      end else begin
         o_da       <= to_offset(i_chan_a.sample);
         o_db       <= to_offset(i_chan_b.sample);
         o_quadrant <= {i_chan_a.positive, i_chan_b.positive};
         o_leds     <= leds_next;
      end
   end

   // ========================================================================
   // dead-timed gate drive
   // ========================================================================

   t_gate            gate_q;
   logic [CNT_W-1:0] dead_cnt;

   // a sign change on A or a disabled converter drops both gates and
   // restarts the dead time, the new gate rises once the count is spent
   always_ff @(posedge ADA_DCO) begin
      if (i_reset) begin
         gate_q   <= '0;
         dead_cnt <= DEAD_LOAD;
      end else if (!i_enable || i_chan_a.crossing) begin
         gate_q   <= '0;
         dead_cnt <= DEAD_LOAD;
      end else if (dead_cnt != '0) begin
         gate_q   <= '0;
         dead_cnt <= dead_cnt - 1'b1;
      end else begin
         gate_q.hi <= i_chan_a.positive;
         gate_q.lo <= ~i_chan_a.positive;
      end
   end

   // switch off takes effect at once
   assign o_gate = i_enable ? gate_q : '0;

endmodule

`default_nettype wire

/* src/resonant_frontend_top.sv */
// Resonant converter ADC front end
`timescale 1ns/1ps
`default_nettype none

module resonant_frontend_top
   import adc_pkg::*;
#(
   parameter int DEAD_TIME = 4
) (
   input  wire          ADA_DCO,
   input  wire          i_reset,
   // ADC channel pins
   input  wire t_adc_raw i_ada_data,
   input  wire t_adc_raw i_adb_data,
   input  wire          i_ada_or,
   input  wire          i_adb_or,
   // data format select and converter switch
   input  wire          i_format,
   input  wire          i_enable,
   // DAC copy-out
   output t_adc_raw     o_da,
   output t_adc_raw     o_db,
   output t_quadrant    o_quadrant,
   output t_gate        o_gate,
   output logic [7:0]   o_leds
);

   // ========================================================================
   // channel capture
   // ========================================================================

   t_chan_status chan_a_status;
   t_chan_status chan_b_status;

   adc_channel chan_a (
      .ADA_DCO      (ADA_DCO),
      .i_reset      (i_reset),
      .i_data       (i_ada_data),
      .i_over_range (i_ada_or),
      .i_format     (i_format),
      .o_status     (chan_a_status)
   );

   // B shares the A data clock
   adc_channel chan_b (
      .ADA_DCO      (ADA_DCO),
      .i_reset      (i_reset),
      .i_data       (i_adb_data),
      .i_over_range (i_adb_or),
      .i_format     (i_format),
      .o_status     (chan_b_status)
   );

   // ========================================================================
   // combiner and gate drive
   // ========================================================================

   bridge_control #(
      .DEAD_TIME (DEAD_TIME)
   ) bridge0 (
      .ADA_DCO    (ADA_DCO),
      .i_reset    (i_reset),
      .i_chan_a   (chan_a_status),
      .i_chan_b   (chan_b_status),
      .i_enable   (i_enable),
      .o_da       (o_da),
      .o_db       (o_db),
      .o_quadrant (o_quadrant),
      .o_gate     (o_gate),
      .o_leds     (o_leds)
   );

endmodule

`default_nettype wire

/* verification/frontend_chk.sv */
// Gate drive and reset checks
`timescale 1ns/1ps
`default_nettype none

module frontend_chk
   import adc_pkg::*;
#(
   parameter int DEAD_TIME = 4
) (
   input wire           ADA_DCO,
   input wire           i_reset,
   input wire           i_enable,
   input wire t_gate    i_gate,
   input wire t_adc_raw i_da,
   input wire t_adc_raw i_db,
   input wire [7:0]     i_leds
);

   // cycles in a row with both gates low, saturating
   int low_run = 0;

   always_ff @(posedge ADA_DCO) begin
      if (i_gate != '0) begin
         low_run <= 0;
      end else if (low_run < DEAD_TIME) begin
         low_run <= low_run + 1;
      end
   end

   no_shoot_through: assert property (@(posedge ADA_DCO) !(i_gate.hi && i_gate.lo))
      else $error("hi and lo gates are high together");

   off_when_disabled: assert property (@(posedge ADA_DCO) !i_enable |-> (i_gate == '0))
      else $error("a gate is high while the converter is disabled");

   dead_time_kept: assert property (@(posedge ADA_DCO) disable iff (i_reset)
      ($rose(i_gate.hi) || $rose(i_gate.lo)) |-> (low_run >= DEAD_TIME))
      else $error("a gate rose before the dead time ran out");

   // outputs one cycle after a reset edge
   reset_state: assert property (@(posedge ADA_DCO) $past(i_reset) |->
      (i_gate == '0 && i_leds == 8'hFF && i_da == MID_SCALE && i_db == MID_SCALE))
      else $error("outputs are not at their reset values");

endmodule

bind bridge_control frontend_chk #(
   .DEAD_TIME (DEAD_TIME)
) chk0 (
   .ADA_DCO  (ADA_DCO),
   .i_reset  (i_reset),
   .i_enable (i_enable),
   .i_gate   (o_gate),
   .i_da     (o_da),
   .i_db     (o_db),
   .i_leds   (o_leds)
);

`default_nettype wire

/* verification/tb_frontend.sv */
// Front end regression testbench
`timescale 1ns/1ps
`default_nettype none

module tb_frontend
   import adc_pkg::*;
();

   localparam int DEAD_TIME    = 4;
   localparam int RESET_CYCLES = 10;
   localparam int HOLD         = 10;
   localparam int RANDOM_ROWS  = 6;
   localparam int MARGIN       = 50;
   localparam int unsigned RAND_SEED = 32'hc8cd546f;

   // one table row, stimulus first, expected values after
   typedef struct packed {
      t_adc_raw   data_a;
      t_adc_raw   data_b;
      logic [1:0] ovr;
      logic       fmt;
      logic       en;
      logic [7:0] hold;
      t_adc_raw   exp_da;
      t_adc_raw   exp_db;
      t_quadrant  exp_quad;
      logic [7:0] exp_leds;
      t_gate      exp_gate;
   } t_row;

   logic       ADA_DCO;
   logic       i_reset;
   t_adc_raw   ada_data;
   t_adc_raw   adb_data;
   logic       ada_or;
   logic       adb_or;
   logic       format;
   logic       enable;
   t_adc_raw   da;
   t_adc_raw   db;
   t_quadrant  quadrant;
   t_gate      gate;
   logic [7:0] leds;

   t_row  rows[$];
   string row_names[$];
   int    cycle_cnt = 0;
   int    cycle_limit = 1000000;

   resonant_frontend_top #(
      .DEAD_TIME (DEAD_TIME)
   ) dut0 (
      .ADA_DCO    (ADA_DCO),
      .i_reset    (i_reset),
      .i_ada_data (ada_data),
      .i_adb_data (adb_data),
      .i_ada_or   (ada_or),
      .i_adb_or   (adb_or),
      .i_format   (format),
      .i_enable   (enable),
      .o_da       (da),
      .o_db       (db),
      .o_quadrant (quadrant),
      .o_gate     (gate),
      .o_leds     (leds)
   );

   always #10 ADA_DCO = ~ADA_DCO;

   // run limit
   always @(posedge ADA_DCO) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt > cycle_limit) begin
         $display("Regression failed");
         $fatal(1, "simulation did not finish within %0d cycles", cycle_limit);
      end
   end

   // ========================================================================
   // table building
   // ========================================================================

   task automatic add_row(input string name, input t_adc_raw data_a, input t_adc_raw data_b,
                          input logic [1:0] ovr, input logic fmt, input logic en,
                          input int hold, input t_adc_raw exp_da, input t_adc_raw exp_db,
                          input t_quadrant exp_quad, input logic [7:0] exp_leds,
                          input t_gate exp_gate);
      t_row r;
      r.data_a   = data_a;
      r.data_b   = data_b;
      r.ovr      = ovr;
      r.fmt      = fmt;
      r.en       = en;
      r.hold     = 8'(hold);
      r.exp_da   = exp_da;
      r.exp_db   = exp_db;
      r.exp_quad = exp_quad;
      r.exp_leds = exp_leds;
      r.exp_gate = exp_gate;
      rows.push_back(r);
      row_names.push_back(name);
   endtask

   // analog level of a pin code under the selected format
   function automatic int level_of(input t_adc_raw code, input logic fmt);
      if (fmt) begin
         return int'(t_sample'(code));
      end
      return int'(code) - int'(MID_SCALE);
   endfunction

   task automatic add_random_row(input int idx);
      t_adc_raw   a;
      t_adc_raw   b;
      logic [1:0] ovr;
      logic       fmt;
      int         lvl_a;
      int         lvl_b;
      logic [7:0] leds_exp;
      a        = t_adc_raw'($urandom);
      b        = t_adc_raw'($urandom);
      ovr      = 2'($urandom);
      fmt      = 1'($urandom);
      lvl_a    = level_of(a, fmt);
      lvl_b    = level_of(b, fmt);
      leds_exp = 8'hFE;
      if (ovr[0]) begin
         leds_exp[3] = 1'b0;
      end
      if (ovr[1]) begin
         leds_exp[4] = 1'b0;
      end
      add_row($sformatf("random_%0d", idx), a, b, ovr, fmt, 1'b1, HOLD,
              t_adc_raw'(lvl_a + int'(MID_SCALE)), t_adc_raw'(lvl_b + int'(MID_SCALE)),
              {lvl_a >= 0, lvl_b >= 0}, leds_exp, (lvl_a >= 0) ? 2'b10 : 2'b01);
   endtask

   // ========================================================================
   // checking
   // ========================================================================

   task automatic compare_value(input string test, input string what,
                                input logic [15:0] expected, input logic [15:0] actual);
      assert (actual == expected) else begin
         $display("FAILED %0s %0s expected %h actual %h", test, what, expected, actual);
         $display("Regression failed");
         $fatal(1, "output mismatch");
      end
   endtask

   task automatic verify_outputs(input string name, input t_row r);
      compare_value(name, "o_da", 16'(r.exp_da), 16'(da));
      compare_value(name, "o_db", 16'(r.exp_db), 16'(db));
      compare_value(name, "o_quadrant", 16'(r.exp_quad), 16'(quadrant));
      compare_value(name, "o_leds", 16'(r.exp_leds), 16'(leds));
   endtask

   task automatic expect_reset_state();
      compare_value("reset", "o_da", 16'(MID_SCALE), 16'(da));
      compare_value("reset", "o_db", 16'(MID_SCALE), 16'(db));
      compare_value("reset", "o_gate", 16'd0, 16'(gate));
      compare_value("reset", "o_leds", 16'h00FF, 16'(leds));
      compare_value("reset", "o_quadrant", 16'd0, 16'(quadrant));
      compare_value("reset", "crossing_a", 16'd0, 16'(dut0.chan_a_status.crossing));
      compare_value("reset", "crossing_b", 16'd0, 16'(dut0.chan_b_status.crossing));
   endtask

   // ends 1 ns after the n-th rising edge
   task automatic wait_cycles(input int n);
      repeat (n) @(posedge ADA_DCO);
      #1;
   endtask

   task automatic run_row(input int idx);
      t_row  r;
      t_row  prev;
      string name;
      r        = rows[idx];
      name     = row_names[idx];
      ada_data = r.data_a;
      adb_data = r.data_b;
      ada_or   = r.ovr[0];
      adb_or   = r.ovr[1];
      format   = r.fmt;
      enable   = r.en;
      // data path latency is two cycles
      wait_cycles(1);
      // one edge in, the previous row is still on the outputs
      if (idx > 0) begin
         prev = rows[idx-1];
         compare_value(name, "o_da held", 16'(prev.exp_da), 16'(da));
         compare_value(name, "o_db held", 16'(prev.exp_db), 16'(db));
         compare_value(name, "o_quadrant held", 16'(prev.exp_quad), 16'(quadrant));
      end
      wait_cycles(1);
      verify_outputs(name, r);
      wait_cycles(DEAD_TIME);
      compare_value(name, "o_gate", 16'(r.exp_gate), 16'(gate));
      wait_cycles(int'(r.hold) - 2 - DEAD_TIME);
      verify_outputs(name, r);
      compare_value(name, "o_gate", 16'(r.exp_gate), 16'(gate));
   endtask

   // ========================================================================
   // main sequence
   // ========================================================================

   initial begin
      int total;
      void'($urandom(RAND_SEED));
      ADA_DCO  = 1'b0;
      i_reset  = 1'b1;
      ada_data = '0;
      adb_data = '0;
      ada_or   = 1'b0;
      adb_or   = 1'b0;
      format   = 1'b0;
      enable   = 1'b0;

      // +1000 and -1000 in both formats, then sign and status cases
      add_row("fmt_ob", 14'h23E8, 14'h1C18, 2'b00, 1'b0, 1'b1, HOLD,
              14'h23E8, 14'h1C18, 2'b10, 8'hFE, 2'b10);
      add_row("fmt_tc", 14'h03E8, 14'h3C18, 2'b00, 1'b1, 1'b1, HOLD,
              14'h23E8, 14'h1C18, 2'b10, 8'hFE, 2'b10);
      add_row("quad_zero", 14'h2000, 14'h2000, 2'b00, 1'b0, 1'b1, HOLD,
              14'h2000, 14'h2000, 2'b11, 8'hFE, 2'b10);
      add_row("quad_np", 14'h1FFF, 14'h2000, 2'b00, 1'b0, 1'b1, HOLD,
              14'h1FFF, 14'h2000, 2'b01, 8'hFE, 2'b01);
      add_row("quad_nn", 14'h1FFF, 14'h1FFF, 2'b00, 1'b0, 1'b1, HOLD,
              14'h1FFF, 14'h1FFF, 2'b00, 8'hFE, 2'b01);
      add_row("quad_pn", 14'h3FFF, 14'h0000, 2'b00, 1'b0, 1'b1, HOLD,
              14'h3FFF, 14'h0000, 2'b10, 8'hFE, 2'b10);
      add_row("or_a", 14'h3FFF, 14'h0000, 2'b01, 1'b0, 1'b1, HOLD,
              14'h3FFF, 14'h0000, 2'b10, 8'hF6, 2'b10);
      add_row("or_b", 14'h3FFF, 14'h0000, 2'b10, 1'b0, 1'b1, HOLD,
              14'h3FFF, 14'h0000, 2'b10, 8'hEE, 2'b10);
      add_row("or_both", 14'h3FFF, 14'h0000, 2'b11, 1'b0, 1'b1, HOLD,
              14'h3FFF, 14'h0000, 2'b10, 8'hE6, 2'b10);
      add_row("disabled_or", 14'h3FFF, 14'h0000, 2'b11, 1'b0, 1'b0, HOLD,
              14'h3FFF, 14'h0000, 2'b10, 8'hFF, 2'b00);
      add_row("disabled_flip", 14'h1FFF, 14'h3FFF, 2'b00, 1'b0, 1'b0, HOLD,
              14'h1FFF, 14'h3FFF, 2'b01, 8'hFF, 2'b00);
      add_row("enable_neg", 14'h1FFF, 14'h3FFF, 2'b00, 1'b0, 1'b1, HOLD,
              14'h1FFF, 14'h3FFF, 2'b01, 8'hFE, 2'b01);
      add_row("tc_full", 14'h2000, 14'h1FFF, 2'b00, 1'b1, 1'b1, HOLD,
              14'h0000, 14'h3FFF, 2'b01, 8'hFE, 2'b01);
      for (int i = 0; i < RANDOM_ROWS; i++) begin
         add_random_row(i);
      end

      total = RESET_CYCLES;
      foreach (rows[i]) begin
         total += int'(rows[i].hold);
      end
      cycle_limit = total + MARGIN;

      wait_cycles(RESET_CYCLES);
      expect_reset_state();
      i_reset = 1'b0;

      foreach (rows[i]) begin
         run_row(i);
      end

      $display("Regression passed");
      $finish;
   end

endmodule

`default_nettype wire
